// File: hdl/obstacle_pkg.sv
package obstacle_pkg;

    ////////////////////////////////////////////////////////////
    // basic types
    ////////////////////////////////////////////////////////////

    // life cycle of the enemy pair
    typedef enum logic [1:0] {
        IDLE  = 2'b00,
        SPAWN = 2'b01,
        CHASE = 2'b10,
        DEATH = 2'b11
    } enemy_state_e;

    typedef logic [11:0] coord_t;   // horizontal or vertical screen position
    typedef logic [11:0] rgb_t;     // 4:4:4 colour
    typedef logic [6:0]  border_t;  // half-width of an enemy square

    ////////////////////////////////////////////////////////////
    // enemy geometry and colours
    ////////////////////////////////////////////////////////////

    localparam border_t ENEMY_SIZE_MAX = 7'd15;
    localparam coord_t  ENEMY_CENTER   = 12'd7;   // cursor offset to centre an enemy on it

    localparam rgb_t SLOW_COLOUR = 12'hff0;  // yellow
    localparam rgb_t FAST_COLOUR = 12'h00f;  // blue

    // play field edges
    localparam coord_t GAME_FIELD_TOP    = 12'd317;
    localparam coord_t GAME_FIELD_BOTTOM = 12'd617;
    localparam coord_t GAME_FIELD_LEFT   = 12'd361;
    localparam coord_t GAME_FIELD_RIGHT  = 12'd661;

    // spawn centres, slow enemy near the top left corner and fast one near the bottom right
    localparam coord_t SLOW_SPAWN_X = GAME_FIELD_LEFT + 12'd19;     // 380
    localparam coord_t SLOW_SPAWN_Y = GAME_FIELD_TOP + 12'd23;      // 340
    localparam coord_t FAST_SPAWN_X = GAME_FIELD_RIGHT - 12'd21;    // 640
    localparam coord_t FAST_SPAWN_Y = GAME_FIELD_BOTTOM - 12'd17;   // 600

    // menu code of the chase level
    localparam logic [3:0] CHASE_LEVEL = 4'd4;

endpackage

// File: hdl/obstacle_ctrl_if.sv
`timescale 1ns/10ps

interface obstacle_ctrl_if (
    input logic clk
);
    import obstacle_pkg::*;

    enemy_state_e phase;        // current life cycle phase
    border_t      border;       // current half-width of both squares
    logic         grow_tick;    // one step of growth or shrink
    logic         life_expired; // chase time is over
    logic         spawn_load;   // round start, reload spawn points

    modport fsm (
        input  clk,
        input  grow_tick,
        input  life_expired,
        output phase,
        output border,
        output spawn_load
    );

    modport timer (input clk, input phase, output grow_tick, output life_expired);

    modport tracker (input clk, input phase, input spawn_load);

    modport overlay (input clk, input phase, input border);

endinterface

// File: hdl/obstacle_fsm.sv
`timescale 1ns/10ps

module obstacle_fsm (
    input  logic         clk,
    input  logic         rst,
    input  logic         done_in,
    input  logic         menu_on,
    input  logic         play_selected,
    input  logic [3:0]   selected,
    obstacle_ctrl_if.fsm ctrl,
    output logic         done
);
    import obstacle_pkg::*;

    logic start;
    logic abort;

    // a round starts only from idle, on the done pulse of the previous stage
    assign start = (ctrl.phase == IDLE) && done_in && play_selected
                   && (selected == CHASE_LEVEL);

    assign abort = menu_on || !play_selected;  // player left the game

    // trackers reload on the same edge that enters spawn
    assign ctrl.spawn_load = start;

    ////////////////////////////////////////////////////////////
    // phase and size register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl.phase  <= IDLE;
            ctrl.border <= '0;
            done        <= 1'b0;
        end else begin
            done <= 1'b0;

            case (ctrl.phase)
                IDLE: begin
                    if (start) begin
                        ctrl.phase  <= SPAWN;
                        ctrl.border <= '0;   // grow from a single pixel
                    end
                end

                SPAWN: begin
                    if (abort) begin
                        ctrl.phase <= IDLE;
                    end else if (ctrl.border == ENEMY_SIZE_MAX) begin
                        ctrl.phase <= CHASE;
                    end else if (ctrl.grow_tick) begin
                        ctrl.border <= ctrl.border + 1'b1;
                    end
                end

                CHASE: begin
                    if (abort) begin
                        ctrl.phase <= IDLE;
                    end else if (ctrl.life_expired) begin
                        ctrl.phase <= DEATH;   // start shrinking from full size
                    end
                end

                DEATH: begin
                    if (abort) begin
                        ctrl.phase <= IDLE;
                    end else if (ctrl.border == '0) begin
                        ctrl.phase <= IDLE;
                        done       <= 1'b1;   // hand over to the next game stage
                    end else if (ctrl.grow_tick) begin
                        ctrl.border <= ctrl.border - 1'b1;
                    end
                end

                default: begin
                    ctrl.phase <= IDLE;
                end
            endcase
        end
    end

endmodule

// File: hdl/pace_timer.sv
`timescale 1ns/10ps

module pace_timer #(
    parameter int GROWTH_TICKS   = 3200000,
    parameter int LIFETIME_TICKS = 650000000
) (
    input  logic           clk,
    input  logic           rst,
    obstacle_ctrl_if.timer ctrl
);
    import obstacle_pkg::*;

    localparam int GROWTH_W = $clog2(GROWTH_TICKS + 2);
    localparam int LIFE_W   = $clog2(LIFETIME_TICKS + 1);

    localparam logic [GROWTH_W-1:0] GROWTH_LAST = GROWTH_W'(GROWTH_TICKS);
    localparam logic [LIFE_W-1:0]   LIFE_LAST   = LIFE_W'(LIFETIME_TICKS - 1);

    logic [GROWTH_W-1:0] growth_cnt;
    logic [LIFE_W-1:0]   life_cnt;
    logic                growth_active;

    // size changes only while the squares grow or shrink
    assign growth_active = (ctrl.phase == SPAWN) || (ctrl.phase == DEATH);

    assign ctrl.grow_tick = growth_active && (growth_cnt == GROWTH_LAST);

    // chase ends after LIFETIME_TICKS cycles in chase
    assign ctrl.life_expired = (ctrl.phase == CHASE) && (life_cnt == LIFE_LAST);

    ////////////////////////////////////////////////////////////
    // counters
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            growth_cnt <= '0;
        end else if (!growth_active || ctrl.grow_tick) begin
            growth_cnt <= '0;   // wrap after GROWTH_TICKS+1 cycles
        end else begin
            growth_cnt <= growth_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            life_cnt <= '0;
        end else if (ctrl.phase != CHASE) begin
            life_cnt <= '0;
        end else if (!ctrl.life_expired) begin
            life_cnt <= life_cnt + 1'b1;   // holds at the last value
        end
    end

endmodule

// File: hdl/chaser_tracker.sv
`timescale 1ns/10ps

module chaser_tracker #(
    parameter int                   MOVE_TICKS = 600000,
    parameter obstacle_pkg::coord_t SPAWN_X    = 12'd0,
    parameter obstacle_pkg::coord_t SPAWN_Y    = 12'd0
) (
    input  logic                 clk,
    input  logic                 rst,
    obstacle_ctrl_if.tracker     ctrl,
    input  obstacle_pkg::coord_t mouse_xpos,
    input  obstacle_pkg::coord_t mouse_ypos,
    output obstacle_pkg::coord_t center_x,
    output obstacle_pkg::coord_t center_y
);
    import obstacle_pkg::*;

    localparam int STEP_W = $clog2(MOVE_TICKS + 2);

    localparam logic [STEP_W-1:0] STEP_LAST = STEP_W'(MOVE_TICKS);

    // index 0 is the horizontal axis, index 1 the vertical one
    localparam coord_t SPAWN_PT [2] = '{SPAWN_X, SPAWN_Y};

    coord_t            target [2];
    coord_t            center [2];
    logic [STEP_W-1:0] step_cnt [2];

    // aim at the cursor shifted so the square ends up centred on it
    assign target[0] = mouse_xpos + ENEMY_CENTER;
    assign target[1] = mouse_ypos + ENEMY_CENTER;

    ////////////////////////////////////////////////////////////
    // one stepper per axis
    ////////////////////////////////////////////////////////////

    for (genvar a = 0; a < 2; a++) begin : g_axis
        logic aligned;
        logic expired;

        assign aligned = (center[a] == target[a]);
        assign expired = (step_cnt[a] == STEP_LAST);

        always_ff @(posedge clk) begin
            if (rst) begin
                center[a]   <= SPAWN_PT[a];
                step_cnt[a] <= '0;
            end else if (ctrl.spawn_load) begin
                center[a]   <= SPAWN_PT[a];   // new round
                step_cnt[a] <= '0;
            end else if (ctrl.phase != CHASE || aligned) begin
                step_cnt[a] <= '0;   // restart the pace on every misalignment
            end else if (expired) begin
                step_cnt[a] <= '0;
                if (center[a] < target[a]) begin
                    center[a] <= center[a] + 1'b1;   // right or down
                end else begin
                    center[a] <= center[a] - 1'b1;   // left or up
                end
            end else begin
                step_cnt[a] <= step_cnt[a] + 1'b1;
            end
        end
    end

    assign center_x = center[0];
    assign center_y = center[1];

endmodule

// File: hdl/sprite_overlay.sv
`timescale 1ns/10ps

module sprite_overlay (
    input  logic                 clk,
    input  logic                 rst,
    obstacle_ctrl_if.overlay     ctrl,
    input  obstacle_pkg::coord_t hcount,
    input  obstacle_pkg::coord_t vcount,
    input  obstacle_pkg::rgb_t   rgb_in,
    input  obstacle_pkg::coord_t slow_x,
    input  obstacle_pkg::coord_t slow_y,
    input  obstacle_pkg::coord_t fast_x,
    input  obstacle_pkg::coord_t fast_y,
    output obstacle_pkg::rgb_t   rgb_out,
    output obstacle_pkg::coord_t obstacle_x,
    output obstacle_pkg::coord_t obstacle_y
);
    import obstacle_pkg::*;

    logic slow_hit;
    logic fast_hit;

    // c-b <= p <= c+b, kept in 13 bits so nothing wraps near the screen edge
    function automatic logic in_span(coord_t p, coord_t c, border_t b);
        logic [12:0] p_ext;
        logic [12:0] c_ext;
        logic [12:0] b_ext;
        p_ext = {1'b0, p};
        c_ext = {1'b0, c};
        b_ext = {6'd0, b};
        return (p_ext + b_ext >= c_ext) && (p_ext <= c_ext + b_ext);
    endfunction

    assign slow_hit = in_span(hcount, slow_x, ctrl.border)
                      && in_span(vcount, slow_y, ctrl.border);
    assign fast_hit = in_span(hcount, fast_x, ctrl.border)
                      && in_span(vcount, fast_y, ctrl.border);

    ////////////////////////////////////////////////////////////
    // output stage, one cycle behind hcount and vcount
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            rgb_out    <= '0;
            obstacle_x <= '0;
            obstacle_y <= '0;
        end else begin
            rgb_out    <= rgb_in;   // background by default
            obstacle_x <= '0;
            obstacle_y <= '0;

            if (ctrl.phase != IDLE) begin
                if (slow_hit) begin
                    rgb_out <= SLOW_COLOUR;   // slow enemy drawn on top
                end else if (fast_hit) begin
                    rgb_out <= FAST_COLOUR;
                end
            end

            // collisions count only while the enemies chase
            if (ctrl.phase == CHASE && (slow_hit || fast_hit)) begin
                obstacle_x <= hcount;
                obstacle_y <= vcount;
            end
        end
    end

endmodule

// File: hdl/obstacle_top.sv
`timescale 1ns/10ps

module obstacle_top #(
    parameter int GROWTH_TICKS   = 3200000,
    parameter int MOVE_TICKS     = 600000,
    parameter int LIFETIME_TICKS = 650000000
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 done_in,
    input  logic                 menu_on,
    input  logic                 play_selected,
    input  logic [3:0]           selected,
    input  obstacle_pkg::coord_t hcount,
    input  obstacle_pkg::coord_t vcount,
    input  obstacle_pkg::coord_t mouse_xpos,
    input  obstacle_pkg::coord_t mouse_ypos,
    input  obstacle_pkg::rgb_t   rgb_in,
    output obstacle_pkg::rgb_t   rgb_out,
    output obstacle_pkg::coord_t obstacle_x,
    output obstacle_pkg::coord_t obstacle_y,
    output logic                 done
);
    import obstacle_pkg::*;

    coord_t slow_x;
    coord_t slow_y;
    coord_t fast_x;
    coord_t fast_y;

    obstacle_ctrl_if ctrl (.clk(clk));

    ////////////////////////////////////////////////////////////
    // control
    ////////////////////////////////////////////////////////////

    obstacle_fsm u_fsm (
        .clk           (clk),
        .rst           (rst),
        .done_in       (done_in),
        .menu_on       (menu_on),
        .play_selected (play_selected),
        .selected      (selected),
        .ctrl          (ctrl.fsm),
        .done          (done)
    );

    pace_timer #(
        .GROWTH_TICKS   (GROWTH_TICKS),
        .LIFETIME_TICKS (LIFETIME_TICKS)
    ) u_timer (
        .clk  (clk),
        .rst  (rst),
        .ctrl (ctrl.timer)
    );

    ////////////////////////////////////////////////////////////
    // enemies and drawing
    ////////////////////////////////////////////////////////////

    chaser_tracker #(
        .MOVE_TICKS (MOVE_TICKS),
        .SPAWN_X    (SLOW_SPAWN_X),
        .SPAWN_Y    (SLOW_SPAWN_Y)
    ) u_slow (
        .clk        (clk),
        .rst        (rst),
        .ctrl       (ctrl.tracker),
        .mouse_xpos (mouse_xpos),
        .mouse_ypos (mouse_ypos),
        .center_x   (slow_x),
        .center_y   (slow_y)
    );

    // twice the speed of the slow one
    chaser_tracker #(
        .MOVE_TICKS (MOVE_TICKS / 2),
        .SPAWN_X    (FAST_SPAWN_X),
        .SPAWN_Y    (FAST_SPAWN_Y)
    ) u_fast (
        .clk        (clk),
        .rst        (rst),
        .ctrl       (ctrl.tracker),
        .mouse_xpos (mouse_xpos),
        .mouse_ypos (mouse_ypos),
        .center_x   (fast_x),
        .center_y   (fast_y)
    );

    sprite_overlay u_overlay (
        .clk        (clk),
        .rst        (rst),
        .ctrl       (ctrl.overlay),
        .hcount     (hcount),
        .vcount     (vcount),
        .rgb_in     (rgb_in),
        .slow_x     (slow_x),
        .slow_y     (slow_y),
        .fast_x     (fast_x),
        .fast_y     (fast_y),
        .rgb_out    (rgb_out),
        .obstacle_x (obstacle_x),
        .obstacle_y (obstacle_y)
    );

endmodule

// File: verif/obstacle_assert.sv
`timescale 1ns/10ps

module obstacle_assert (
    input logic                       clk,
    input logic                       rst,
    input logic                       done,
    input obstacle_pkg::enemy_state_e phase,
    input obstacle_pkg::border_t      border
);
    import obstacle_pkg::*;

    // handover to the next stage is a single cycle
    done_one_cycle: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("done stayed high for more than one cycle");

    border_in_range: assert property (@(posedge clk) disable iff (rst)
                                      border <= ENEMY_SIZE_MAX)
        else $error("border grew above the full enemy size");

    idle_after_done: assert property (@(posedge clk) disable iff (rst)
                                      done |=> phase == IDLE)
        else $error("phase was not idle on the cycle after done");

endmodule

bind obstacle_fsm obstacle_assert u_fsm_assert (
    .clk    (clk),
    .rst    (rst),
    .done   (done),
    .phase  (ctrl.phase),
    .border (ctrl.border)
);

// File: verif/obstacle_tb.sv
`timescale 1ns/10ps

module obstacle_tb;
    import obstacle_pkg::*;

    localparam rgb_t BG_COLOUR = 12'h3c6;   // background under every probe

    logic        clk;
    logic        rst;
    logic        done_in;
    logic        menu_on;
    logic        play_selected;
    logic [3:0]  selected;
    coord_t      hcount;
    coord_t      vcount;
    coord_t      mouse_xpos;
    coord_t      mouse_ypos;
    rgb_t        rgb_in;
    rgb_t        rgb_out;
    coord_t      obstacle_x;
    coord_t      obstacle_y;
    logic        done;
    logic [31:0] rng_state;
    coord_t      target_x;   // cursor plus ENEMY_CENTER in the chase test
    coord_t      target_y;

    obstacle_top #(
        .GROWTH_TICKS   (3),
        .MOVE_TICKS     (4),
        .LIFETIME_TICKS (400)
    ) obstacle_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            stop_with_error($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h",
                                      name, got, exp));
        end
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic near(input coord_t p, input coord_t c, input int b);
        return (int'(p) >= int'(c) - b) && (int'(p) <= int'(c) + b);
    endfunction

    // expected colour with both enemies at their spawn centres
    function automatic rgb_t model_rgb(input coord_t x, input coord_t y, input logic shown,
                                       input int b);
        if (shown && near(x, SLOW_SPAWN_X, b) && near(y, SLOW_SPAWN_Y, b)) begin
            return SLOW_COLOUR;   // slow one on top
        end
        if (shown && near(x, FAST_SPAWN_X, b) && near(y, FAST_SPAWN_Y, b)) begin
            return FAST_COLOUR;
        end
        return BG_COLOUR;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // outputs of this pixel are valid when the task returns
    task automatic probe(input coord_t x, input coord_t y);
        hcount = x;
        vcount = y;
        rgb_in = BG_COLOUR;
        next_cycle();
    endtask

    task automatic pulse_done_in(input logic [3:0] code, input logic play);
        selected      = code;
        play_selected = play;
        done_in       = 1'b1;
        next_cycle();
        done_in = 1'b0;
    endtask

    // pixels 1..12 outside the target-side edge stay covered only while the enemy lags
    task automatic scan_lag(input logic vertical, output int lag);
        int     j;
        coord_t px;
        coord_t py;
        lag = 0;
        for (j = 1; j <= 12; j++) begin
            px = vertical ? target_x : coord_t'(target_x - 15 - j);
            py = vertical ? coord_t'(target_y - 15 - j) : target_y;
            probe(px, py);
            if (obstacle_x == px && obstacle_y == py) begin
                lag++;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////

    task automatic test_start_gating();
        int n;
        pulse_done_in(4'd3, 1'b1);   // wrong level
        for (n = 0; n < 20; n++) begin
            probe(SLOW_SPAWN_X, SLOW_SPAWN_Y);
            check("rgb_out", rgb_out, BG_COLOUR);
        end
        pulse_done_in(CHASE_LEVEL, 1'b0);   // right level but play not selected
        for (n = 0; n < 20; n++) begin
            probe(SLOW_SPAWN_X, SLOW_SPAWN_Y);
            check("rgb_out", rgb_out, BG_COLOUR);
        end
        pulse_done_in(CHASE_LEVEL, 1'b1);
        n = 0;
        do begin
            probe(SLOW_SPAWN_X, SLOW_SPAWN_Y);
            n++;
            if (n > 20) begin
                stop_with_error("slow enemy did not appear after a valid start");
            end
        end while (rgb_out !== SLOW_COLOUR);
    endtask

    task automatic test_growth();
        int n;
        n = 0;
        // full size is first seen while the phase is still spawn
        do begin
            probe(SLOW_SPAWN_X + 12'd15, SLOW_SPAWN_Y);
            check("obstacle_x", obstacle_x, 0);
            check("obstacle_y", obstacle_y, 0);
            n++;
            if (n > 100) begin
                stop_with_error("enemy never grew to full size");
            end
        end while (rgb_out !== SLOW_COLOUR);
        probe(FAST_SPAWN_X, FAST_SPAWN_Y);
        check("rgb_out", rgb_out, model_rgb(FAST_SPAWN_X, FAST_SPAWN_Y, 1'b1, 15));
        probe(SLOW_SPAWN_X + 12'd16, SLOW_SPAWN_Y);
        check("rgb_out", rgb_out, model_rgb(SLOW_SPAWN_X + 12'd16, SLOW_SPAWN_Y, 1'b1, 15));
        probe(SLOW_SPAWN_X - 12'd16, SLOW_SPAWN_Y);
        check("rgb_out", rgb_out, model_rgb(SLOW_SPAWN_X - 12'd16, SLOW_SPAWN_Y, 1'b1, 15));
        probe(SLOW_SPAWN_X, SLOW_SPAWN_Y + 12'd16);
        check("rgb_out", rgb_out, model_rgb(SLOW_SPAWN_X, SLOW_SPAWN_Y + 12'd16, 1'b1, 15));
    endtask

    task automatic test_chase();
        int     ox;
        int     oy;
        int     lag_x;
        int     lag_y;
        int     last;
        int     scans;
        coord_t pix;
        coord_t pix_y;
        rng_state = xorshift(rng_state);
        ox = 3 + int'(rng_state % 10);
        rng_state = xorshift(rng_state);
        oy = 3 + int'(rng_state % 10);
        target_x   = coord_t'(SLOW_SPAWN_X + ox);   // right of and below the slow spawn
        target_y   = coord_t'(SLOW_SPAWN_Y + oy);
        mouse_xpos = target_x - ENEMY_CENTER;
        mouse_ypos = target_y - ENEMY_CENTER;
        last  = 24;
        scans = 0;
        do begin
            scan_lag(1'b0, lag_x);
            scan_lag(1'b1, lag_y);
            if (lag_x + lag_y > last) begin
                stop_with_error($sformatf("slow enemy moved away, distance %0d after %0d",
                                          lag_x + lag_y, last));
            end
            last = lag_x + lag_y;
            scans++;
            if (scans > 20) begin
                stop_with_error("slow enemy never reached the cursor");
            end
        end while (last != 0);
        // the fast one has covered more than the slow one's largest axis distance
        pix   = coord_t'(FAST_SPAWN_X - 16 - ((ox > oy) ? ox : oy));
        pix_y = pix - (FAST_SPAWN_X - FAST_SPAWN_Y);
        probe(pix, pix_y);
        check("obstacle_x", obstacle_x, pix);
        check("obstacle_y", obstacle_y, pix_y);
    endtask

    task automatic test_collision_report();
        probe(target_x, target_y);
        check("obstacle_x", obstacle_x, target_x);
        check("obstacle_y", obstacle_y, target_y);
        check("rgb_out", rgb_out, SLOW_COLOUR);
        probe(target_x - 12'd15, target_y + 12'd15);   // corner pixel
        check("obstacle_x", obstacle_x, target_x - 12'd15);
        check("obstacle_y", obstacle_y, target_y + 12'd15);
        probe(target_x + 12'd16, target_y);
        check("obstacle_x", obstacle_x, 0);
        check("obstacle_y", obstacle_y, 0);
        check("rgb_out", rgb_out, BG_COLOUR);
    endtask

    task automatic test_death_done();
        int n;
        int pulses;
        n = 0;
        while (done !== 1'b1) begin
            next_cycle();
            n++;
            if (n > 600) begin
                stop_with_error("done never pulsed after the chase lifetime");
            end
        end
        pulses = 1;
        for (n = 0; n < 50; n++) begin
            next_cycle();
            pulses += (done === 1'b1) ? 1 : 0;
        end
        check("done pulses", pulses, 1);
        probe(SLOW_SPAWN_X, SLOW_SPAWN_Y);
        check("rgb_out", rgb_out, model_rgb(SLOW_SPAWN_X, SLOW_SPAWN_Y, 1'b0, 15));
        probe(FAST_SPAWN_X, FAST_SPAWN_Y);
        check("rgb_out", rgb_out, model_rgb(FAST_SPAWN_X, FAST_SPAWN_Y, 1'b0, 15));
        probe(target_x, target_y);
        check("rgb_out", rgb_out, BG_COLOUR);
    endtask

    task automatic test_abort();
        int n;
        mouse_xpos = SLOW_SPAWN_X - ENEMY_CENTER;   // slow enemy stays put
        mouse_ypos = SLOW_SPAWN_Y - ENEMY_CENTER;
        pulse_done_in(CHASE_LEVEL, 1'b1);
        n = 0;
        do begin
            probe(SLOW_SPAWN_X, SLOW_SPAWN_Y);
            n++;
            if (n > 150) begin
                stop_with_error("second round never reached the chase");
            end
        end while (obstacle_x !== SLOW_SPAWN_X);
        for (n = 0; n < 50; n++) begin
            probe(SLOW_SPAWN_X, SLOW_SPAWN_Y);
            check("rgb_out", rgb_out, SLOW_COLOUR);
        end
        menu_on = 1'b1;
        probe(SLOW_SPAWN_X, SLOW_SPAWN_Y);   // still chase on this edge
        for (n = 0; n < 20; n++) begin
            probe(SLOW_SPAWN_X, SLOW_SPAWN_Y);
            check("rgb_out", rgb_out, BG_COLOUR);
            check("obstacle_x", obstacle_x, 0);
            check("done", done, 0);
        end
        menu_on = 1'b0;
        for (n = 0; n < 500; n++) begin
            next_cycle();
            check("done", done, 0);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        rng_state     = 32'h5ba6dd05;
        rst           = 1'b1;
        done_in       = 1'b0;
        menu_on       = 1'b0;
        play_selected = 1'b1;
        selected      = 4'd0;
        hcount        = '0;
        vcount        = '0;
        mouse_xpos    = SLOW_SPAWN_X - ENEMY_CENTER;
        mouse_ypos    = SLOW_SPAWN_Y - ENEMY_CENTER;
        rgb_in        = BG_COLOUR;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        check("rgb_out", rgb_out, 0);
        check("obstacle_x", obstacle_x, 0);
        check("obstacle_y", obstacle_y, 0);
        check("done", done, 0);
        test_start_gating();
        test_growth();
        test_chase();
        test_collision_report();
        test_death_done();
        test_abort();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: tb.f
hdl/obstacle_pkg.sv
hdl/obstacle_ctrl_if.sv
hdl/obstacle_fsm.sv
hdl/pace_timer.sv
hdl/chaser_tracker.sv
hdl/sprite_overlay.sv
hdl/obstacle_top.sv
verif/obstacle_assert.sv
verif/obstacle_tb.sv
